// File: verilog/rcfg_macros.svh
/*
 * Shared sizes for the reconfiguration front end:
 * channel count, address and data widths,
 * the soft block select bit and the soft register indices
 */
`ifndef RCFG_MACROS_SVH
`define RCFG_MACROS_SVH

// Channel group and shared bus geometry
`define RCFG_CHANNELS     4
`define RCFG_SEL_BITS     2
`define RCFG_ADDR_BITS    10
`define RCFG_DATA_WIDTH   32
`define XCVR_DATA_WIDTH   8

// Upper half of each channel window maps to the soft block
`define RCFG_CSR_BIT      9

// Soft register map
`define CSR_REG_STATUS    4'd0
`define CSR_REG_CTRL_VAL  4'd1
`define CSR_REG_CTRL_EN   4'd2
`define CSR_REG_CAL_MASK  4'd3

`endif

// File: verilog/rcfg_bus_pkg.sv
/*
 * Reconfiguration bus types:
 * channel address union (transceiver view and soft register view),
 * captured user request, transceiver register port request
 */
`include "rcfg_macros.svh"

package rcfg_bus_pkg;

  // Soft register view of a channel address
  typedef struct packed {
    logic                        sel;
    logic [`RCFG_CSR_BIT-5:0]    rsvd;
    logic [3:0]                  index;
  } csr_addr_t;

  // One channel address, read either as a raw register address or a CSR index
  typedef union packed {
    logic [`RCFG_ADDR_BITS-1:0]  raw;
    csr_addr_t                   csr;
  } rcfg_addr_u;

  // Request as captured from the shared bus
  typedef struct packed {
    logic                        read;
    logic                        write;
    logic [`RCFG_SEL_BITS-1:0]   chan_sel;
    rcfg_addr_u                  address;
    logic [`RCFG_DATA_WIDTH-1:0] writedata;
  } rcfg_req_t;

  // Request towards the transceiver 8-bit register port
  typedef struct packed {
    logic                        read;
    logic                        write;
    logic [`RCFG_ADDR_BITS-1:0]  address;
    logic [`XCVR_DATA_WIDTH-1:0] writedata;
  } xcvr_avmm_req_t;

endpackage

// File: verilog/xcvr_ctrl_pkg.sv
/*
 * PHY side types:
 * status lines, control lines and calibration busy masks
 */

package xcvr_ctrl_pkg;

  // Status lines sampled by the soft block, bit 0 last
  typedef struct packed {
    logic avmm_busy;
    logic rx_cal_busy;
    logic tx_cal_busy;
    logic rx_is_lockedtodata;
    logic rx_is_lockedtoref;
  } xcvr_status_t;

  // PHY control lines, prbs_err_clr at bit 0
  typedef struct packed {
    logic tx_digitalreset;
    logic tx_analogreset;
    logic rx_digitalreset;
    logic rx_analogreset;
    logic en_serial_lpbk;
    logic set_rx_locktodata;
    logic set_rx_locktoref;
    logic prbs_err_clr;
  } xcvr_ctrl_t;

  typedef struct packed {
    logic rx_cal_busy_mask;
    logic tx_cal_busy_mask;
  } cal_mask_t;

endpackage

// File: verilog/rcfg_req_stage.sv
/*
 * Request stage of the shared reconfiguration bus:
 * captures one read or write, steers it to the channel picked by
 * the upper address bits and returns a one-cycle completion
 */
`include "rcfg_macros.svh"

module rcfg_req_stage
  import rcfg_bus_pkg::*;
(
  input  logic                                reconfig_clk,
  input  logic                                rst_n,
  input  logic                                reconfig_read,
  input  logic                                reconfig_write,
  input  logic [`RCFG_SEL_BITS+`RCFG_ADDR_BITS-1:0] reconfig_address,
  input  logic [`RCFG_DATA_WIDTH-1:0]         reconfig_writedata,
  output logic [`RCFG_DATA_WIDTH-1:0]         reconfig_readdata,
  output logic                                reconfig_waitrequest,
  output rcfg_req_t                           chan_req [`RCFG_CHANNELS],
  input  logic [`RCFG_CHANNELS-1:0]           chan_done,
  input  logic [`RCFG_DATA_WIDTH-1:0]         chan_readdata [`RCFG_CHANNELS]
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,
    ST_CMPL
  } stage_state_t;

  stage_state_t state;
  rcfg_req_t    req_q;
  logic         take;
  logic         sel_done;

  assign take     = (state == ST_IDLE) && (reconfig_read || reconfig_write);
  assign sel_done = (state == ST_BUSY) && chan_done[req_q.chan_sel];

  always_ff @(posedge reconfig_clk or negedge rst_n) begin
    if (!rst_n) begin
      state                <= ST_IDLE;
      reconfig_waitrequest <= 1'b1;
    end else begin
      case (state)
        ST_IDLE: if (take) state <= ST_BUSY;
        ST_BUSY: begin
          if (sel_done) begin
            state                <= ST_CMPL;
            reconfig_waitrequest <= 1'b0;
          end
        end
        // One completion cycle, bus is not sampled here
        default: begin
          state                <= ST_IDLE;
          reconfig_waitrequest <= 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge reconfig_clk) begin
    if (take) begin
      req_q.read      <= reconfig_read;
      req_q.write     <= reconfig_write;
      req_q.chan_sel  <= reconfig_address[`RCFG_ADDR_BITS +: `RCFG_SEL_BITS];
      req_q.address   <= reconfig_address[`RCFG_ADDR_BITS-1:0];
      req_q.writedata <= reconfig_writedata;
    end
    if (sel_done) reconfig_readdata <= chan_readdata[req_q.chan_sel];
  end

  // Strobes only reach the selected slot, address and data go to all
  always_comb begin
    for (int i = 0; i < `RCFG_CHANNELS; i++) begin
      chan_req[i]       = req_q;
      chan_req[i].read  = (state == ST_BUSY) && req_q.read &&
                          (req_q.chan_sel == `RCFG_SEL_BITS'(i));
      chan_req[i].write = (state == ST_BUSY) && req_q.write &&
                          (req_q.chan_sel == `RCFG_SEL_BITS'(i));
    end
  end

endmodule

// File: verilog/rcfg_soft_csr.sv
/*
 * Soft control and status registers for one channel:
 * synchronized PHY status, per-bit override of the PHY control
 * lines and the two calibration busy masks
 */
`include "rcfg_macros.svh"

module rcfg_soft_csr
  import xcvr_ctrl_pkg::*;
(
  input  logic                        reconfig_clk,
  input  logic                        rst_n,
  input  logic                        csr_read,
  input  logic                        csr_write,
  input  logic [3:0]                  csr_index,
  input  logic [`XCVR_DATA_WIDTH-1:0] csr_writedata,
  output logic                        csr_ack,
  output logic [`XCVR_DATA_WIDTH-1:0] csr_readdata,
  input  xcvr_status_t                status,
  input  xcvr_ctrl_t                  ctrl_in,
  output xcvr_ctrl_t                  ctrl_out,
  output cal_mask_t                   cal_mask
);

  xcvr_status_t status_meta;
  xcvr_status_t status_q;
  xcvr_ctrl_t   ctrl_val;
  xcvr_ctrl_t   ctrl_en;

  // Status lines come from other clock domains
  always_ff @(posedge reconfig_clk or negedge rst_n) begin
    if (!rst_n) begin
      status_meta <= '0;
      status_q    <= '0;
    end else begin
      status_meta <= status;
      status_q    <= status_meta;
    end
  end

  always_ff @(posedge reconfig_clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_val <= '0;
      ctrl_en  <= '0;
      cal_mask <= 2'b11;
    end else if (csr_write) begin
      case (csr_index)
        `CSR_REG_CTRL_VAL: ctrl_val <= csr_writedata;
        `CSR_REG_CTRL_EN:  ctrl_en  <= csr_writedata;
        `CSR_REG_CAL_MASK: cal_mask <= csr_writedata[1:0];
        // Status and unmapped indices are read only
        default: ;
      endcase
    end
  end

  always_ff @(posedge reconfig_clk or negedge rst_n) begin
    if (!rst_n) begin
      csr_ack <= 1'b0;
    end else begin
      csr_ack <= csr_read || csr_write;
    end
  end

  always_ff @(posedge reconfig_clk) begin
    if (csr_read) begin
      case (csr_index)
        `CSR_REG_STATUS:   csr_readdata <= `XCVR_DATA_WIDTH'(status_q);
        `CSR_REG_CTRL_VAL: csr_readdata <= ctrl_val;
        `CSR_REG_CTRL_EN:  csr_readdata <= ctrl_en;
        `CSR_REG_CAL_MASK: csr_readdata <= `XCVR_DATA_WIDTH'(cal_mask);
        default:           csr_readdata <= '0;
      endcase
    end
  end

  // Enabled bits take the register value, others pass the PHY control through
  assign ctrl_out = xcvr_ctrl_t'((ctrl_val & ctrl_en) | (ctrl_in & ~ctrl_en));

endmodule

// File: verilog/rcfg_chan_port.sv
/*
 * Per-channel port of the reconfiguration front end:
 * routes a request to the transceiver register port or the soft
 * register block by address bit 9, narrows write data to 8 bits
 * and zero-extends read data back to 32 bits
 */
`include "rcfg_macros.svh"

module rcfg_chan_port
  import rcfg_bus_pkg::*, xcvr_ctrl_pkg::*;
(
  input  logic                        reconfig_clk,
  input  logic                        rst_n,
  input  rcfg_req_t                   chan_req,
  output logic                        chan_done,
  output logic [`RCFG_DATA_WIDTH-1:0] chan_readdata,
  output xcvr_avmm_req_t              avmm_req,
  input  logic [`XCVR_DATA_WIDTH-1:0] avmm_readdata,
  input  logic                        avmm_waitrequest,
  input  xcvr_status_t                status,
  input  xcvr_ctrl_t                  ctrl_in,
  output xcvr_ctrl_t                  ctrl_out,
  output cal_mask_t                   cal_mask
);

  logic                        issued;
  logic                        start;
  logic                        csr_path;
  logic                        avmm_rd;
  logic                        avmm_wr;
  logic                        avmm_active;
  logic [`RCFG_ADDR_BITS-1:0]  avmm_addr;
  logic [`XCVR_DATA_WIDTH-1:0] avmm_wdata;
  logic                        csr_read;
  logic                        csr_write;
  logic                        csr_ack;
  logic [`XCVR_DATA_WIDTH-1:0] csr_readdata;

  assign csr_path    = chan_req.address.csr.sel;
  // New request only when the stage has not been served yet
  assign start       = (chan_req.read || chan_req.write) && !issued;
  assign avmm_active = avmm_rd || avmm_wr;

  always_ff @(posedge reconfig_clk or negedge rst_n) begin
    if (!rst_n) begin
      issued    <= 1'b0;
      avmm_rd   <= 1'b0;
      avmm_wr   <= 1'b0;
      csr_read  <= 1'b0;
      csr_write <= 1'b0;
    end else begin
      issued    <= chan_req.read || chan_req.write;
      csr_read  <= start && csr_path && chan_req.read;
      csr_write <= start && csr_path && chan_req.write;
      if (start && !csr_path) begin
        avmm_rd <= chan_req.read;
        avmm_wr <= chan_req.write;
      end else if (avmm_active && !avmm_waitrequest) begin
        avmm_rd <= 1'b0;
        avmm_wr <= 1'b0;
      end
    end
  end

  // Address and data held with the strobes until the port accepts
  always_ff @(posedge reconfig_clk) begin
    if (start && !csr_path) begin
      avmm_addr  <= chan_req.address.raw;
      avmm_wdata <= chan_req.writedata[`XCVR_DATA_WIDTH-1:0];
    end
  end

  assign avmm_req = '{read:      avmm_rd,
                      write:     avmm_wr,
                      address:   avmm_addr,
                      writedata: avmm_wdata};

  assign chan_done     = (avmm_active && !avmm_waitrequest) || csr_ack;
  assign chan_readdata = {{(`RCFG_DATA_WIDTH-`XCVR_DATA_WIDTH){1'b0}},
                          csr_ack ? csr_readdata : avmm_readdata};

  rcfg_soft_csr i_soft_csr (
    .reconfig_clk  (reconfig_clk),
    .rst_n         (rst_n),
    .csr_read      (csr_read),
    .csr_write     (csr_write),
    .csr_index     (chan_req.address.csr.index),
    .csr_writedata (chan_req.writedata[`XCVR_DATA_WIDTH-1:0]),
    .csr_ack       (csr_ack),
    .csr_readdata  (csr_readdata),
    .status        (status),
    .ctrl_in       (ctrl_in),
    .ctrl_out      (ctrl_out),
    .cal_mask      (cal_mask)
  );

endmodule

// File: verilog/rcfg_top.sv
/*
 * Reconfiguration front end top level:
 * shared user bus request stage feeding one channel port
 * per transceiver channel
 */
`include "rcfg_macros.svh"

module rcfg_top
  import rcfg_bus_pkg::*, xcvr_ctrl_pkg::*;
(
  input  logic                                reconfig_clk,
  input  logic                                rst_n,
  input  logic                                reconfig_read,
  input  logic                                reconfig_write,
  input  logic [`RCFG_SEL_BITS+`RCFG_ADDR_BITS-1:0] reconfig_address,
  input  logic [`RCFG_DATA_WIDTH-1:0]         reconfig_writedata,
  output logic [`RCFG_DATA_WIDTH-1:0]         reconfig_readdata,
  output logic                                reconfig_waitrequest,

  // Per-channel transceiver register ports
  output xcvr_avmm_req_t                      avmm_req [`RCFG_CHANNELS],
  input  logic [`XCVR_DATA_WIDTH-1:0]         avmm_readdata [`RCFG_CHANNELS],
  input  logic [`RCFG_CHANNELS-1:0]           avmm_waitrequest,

  // Per-channel PHY status and control
  input  xcvr_status_t                        status [`RCFG_CHANNELS],
  input  xcvr_ctrl_t                          ctrl_in [`RCFG_CHANNELS],
  output xcvr_ctrl_t                          ctrl_out [`RCFG_CHANNELS],
  output cal_mask_t                           cal_mask [`RCFG_CHANNELS]
);

  rcfg_req_t                   chan_req [`RCFG_CHANNELS];
  logic [`RCFG_CHANNELS-1:0]   chan_done;
  logic [`RCFG_DATA_WIDTH-1:0] chan_readdata [`RCFG_CHANNELS];

  rcfg_req_stage i_req_stage (
    .reconfig_clk         (reconfig_clk),
    .rst_n                (rst_n),
    .reconfig_read        (reconfig_read),
    .reconfig_write       (reconfig_write),
    .reconfig_address     (reconfig_address),
    .reconfig_writedata   (reconfig_writedata),
    .reconfig_readdata    (reconfig_readdata),
    .reconfig_waitrequest (reconfig_waitrequest),
    .chan_req             (chan_req),
    .chan_done            (chan_done),
    .chan_readdata        (chan_readdata)
  );

  for (genvar gi = 0; gi < `RCFG_CHANNELS; gi++) begin : g_chan
    rcfg_chan_port i_chan_port (
      .reconfig_clk     (reconfig_clk),
      .rst_n            (rst_n),
      .chan_req         (chan_req[gi]),
      .chan_done        (chan_done[gi]),
      .chan_readdata    (chan_readdata[gi]),
      .avmm_req         (avmm_req[gi]),
      .avmm_readdata    (avmm_readdata[gi]),
      .avmm_waitrequest (avmm_waitrequest[gi]),
      .status           (status[gi]),
      .ctrl_in          (ctrl_in[gi]),
      .ctrl_out         (ctrl_out[gi]),
      .cal_mask         (cal_mask[gi])
    );
  end

endmodule

// File: tb/xcvr_avmm_responder.sv
/*
 * Behavioral transceiver register port for one channel:
 * 1024 byte registers with an address based fill
 * and 0 to 3 random wait cycles per access
 */
`include "rcfg_macros.svh"

module xcvr_avmm_responder
  import rcfg_bus_pkg::*;
#(
  parameter int CHAN_ID = 0
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  xcvr_avmm_req_t              avmm_req,
  output logic [`XCVR_DATA_WIDTH-1:0] avmm_readdata,
  output logic                        avmm_waitrequest
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [`XCVR_DATA_WIDTH-1:0] regs [1024];
  logic [1:0]                  wait_left;

  // Wait count for the next access is drawn when the current one ends
  assign avmm_waitrequest = (wait_left != 2'd0);
  assign avmm_readdata    = regs[avmm_req.address];

  always @(posedge clk) begin
    if (!rst_n) begin
      for (int a = 0; a < 1024; a++) begin
        regs[a] <= 8'(a * 37 + (a >> 8) * 11 + CHAN_ID * 101);
      end
      wait_left <= 2'd0;
    end else if (avmm_req.read || avmm_req.write) begin
      if (wait_left != 2'd0) begin
        wait_left <= wait_left - 2'd1;
      end else begin
        if (avmm_req.write) regs[avmm_req.address] <= avmm_req.writedata;
        wait_left <= 2'($urandom_range(3, 0));
      end
    end
  end

endmodule

// File: tb/tb_rcfg_top.sv
/*
 * Testbench for the reconfiguration front end:
 * clock and reset, one register port responder per channel,
 * random bus transfers checked against a reference model
 */
`include "rcfg_macros.svh"

module tb_rcfg_top
  import rcfg_bus_pkg::*, xcvr_ctrl_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_XFERS  = 400;
  localparam int WAIT_LIMIT = 20;

  logic                                      reconfig_clk;
  logic                                      rst_n;
  logic                                      reconfig_read;
  logic                                      reconfig_write;
  logic [`RCFG_SEL_BITS+`RCFG_ADDR_BITS-1:0] reconfig_address;
  logic [`RCFG_DATA_WIDTH-1:0]               reconfig_writedata;
  logic [`RCFG_DATA_WIDTH-1:0]               reconfig_readdata;
  logic                                      reconfig_waitrequest;
  xcvr_avmm_req_t                            avmm_req [`RCFG_CHANNELS];
  logic [`XCVR_DATA_WIDTH-1:0]               avmm_readdata [`RCFG_CHANNELS];
  logic [`RCFG_CHANNELS-1:0]                 avmm_waitrequest;
  xcvr_status_t                              status [`RCFG_CHANNELS];
  xcvr_ctrl_t                                ctrl_in [`RCFG_CHANNELS];
  xcvr_ctrl_t                                ctrl_out [`RCFG_CHANNELS];
  cal_mask_t                                 cal_mask [`RCFG_CHANNELS];

  // Reference model per channel
  logic [7:0] exp_regs [`RCFG_CHANNELS][1024];
  logic [7:0] exp_val [`RCFG_CHANNELS];
  logic [7:0] exp_en [`RCFG_CHANNELS];
  logic [1:0] exp_cal [`RCFG_CHANNELS];

  rcfg_top i_rcfg_top (.*);

  for (genvar gi = 0; gi < `RCFG_CHANNELS; gi++) begin : g_resp
    xcvr_avmm_responder #(.CHAN_ID(gi)) i_resp (
      .clk              (reconfig_clk),
      .rst_n            (rst_n),
      .avmm_req         (avmm_req[gi]),
      .avmm_readdata    (avmm_readdata[gi]),
      .avmm_waitrequest (avmm_waitrequest[gi])
    );
  end

  initial begin
    reconfig_clk = 1'b0;
    forever #5 reconfig_clk = ~reconfig_clk;
  end

  task automatic abort_run();
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  function automatic logic [7:0] csr_expect(input int ch, input logic [3:0] idx);
    case (idx)
      `CSR_REG_STATUS:   return {3'b000, status[ch]};
      `CSR_REG_CTRL_VAL: return exp_val[ch];
      `CSR_REG_CTRL_EN:  return exp_en[ch];
      `CSR_REG_CAL_MASK: return {6'd0, exp_cal[ch]};
      default:           return 8'd0;
    endcase
  endfunction

  function automatic void model_csr_write(input int ch, input logic [3:0] idx,
                                          input logic [7:0] data);
    case (idx)
      `CSR_REG_CTRL_VAL: exp_val[ch] = data;
      `CSR_REG_CTRL_EN:  exp_en[ch]  = data;
      `CSR_REG_CAL_MASK: exp_cal[ch] = data[1:0];
      default: ;
    endcase
  endfunction

  // Only the addressed channel may see a transceiver strobe
  task automatic verify_strobe_routing(input int active_ch);
    for (int c = 0; c < `RCFG_CHANNELS; c++) begin
      if (c != active_ch) begin
        check_value($sformatf("avmm_req[%0d] strobes", c),
                    32'({avmm_req[c].read, avmm_req[c].write}), 32'd0);
      end
    end
  endtask

  task automatic check_phy_outputs();
    logic [7:0] exp_ctrl;
    logic [7:0] phy_in;
    for (int c = 0; c < `RCFG_CHANNELS; c++) begin
      phy_in = ctrl_in[c];
      // Enabled bits come from the value register
      for (int b = 0; b < 8; b++) begin
        exp_ctrl[b] = exp_en[c][b] ? exp_val[c][b] : phy_in[b];
      end
      check_value($sformatf("ctrl_out[%0d]", c), 32'(ctrl_out[c]), 32'(exp_ctrl));
      check_value($sformatf("cal_mask[%0d]", c), 32'(cal_mask[c]), 32'(exp_cal[c]));
    end
    verify_strobe_routing(-1);
  endtask

  task automatic randomize_phy_inputs();
    for (int c = 0; c < `RCFG_CHANNELS; c++) begin
      status[c]  = xcvr_status_t'(5'($urandom));
      ctrl_in[c] = xcvr_ctrl_t'(8'($urandom));
    end
    // Let the status synchronizers settle
    repeat (3) @(negedge reconfig_clk);
    check_phy_outputs();
  endtask

  // One bus transfer, held until waitrequest drops
  task automatic bus_access(input logic wr, input int ch, input logic [9:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output int cycles);
    reconfig_read      = ~wr;
    reconfig_write     = wr;
    reconfig_address   = {2'(ch), addr};
    reconfig_writedata = wdata;
    cycles = 0;
    do begin
      @(negedge reconfig_clk);
      cycles++;
      verify_strobe_routing(addr[9] ? -1 : ch);
    end while (reconfig_waitrequest && cycles < WAIT_LIMIT);
    if (reconfig_waitrequest) begin
      $display("Timeout: no completion for the transfer on channel %0d", ch);
      abort_run();
    end
    rdata          = reconfig_readdata;
    reconfig_read  = 1'b0;
    reconfig_write = 1'b0;
  endtask

  initial begin
    logic [31:0] rdata;
    logic [31:0] wdata;
    logic [9:0]  addr;
    logic [3:0]  idx;
    logic        wr;
    int          ch;
    int          cycles;
    void'($urandom(32'hf01c_8a8b));
    rst_n              = 1'b0;
    reconfig_read      = 1'b0;
    reconfig_write     = 1'b0;
    reconfig_address   = '0;
    reconfig_writedata = '0;
    for (int c = 0; c < `RCFG_CHANNELS; c++) begin
      status[c]  = xcvr_status_t'(5'($urandom));
      ctrl_in[c] = xcvr_ctrl_t'(8'($urandom));
      exp_val[c] = 8'd0;
      exp_en[c]  = 8'd0;
      exp_cal[c] = 2'b11;
      for (int a = 0; a < 1024; a++) exp_regs[c][a] = 8'(a * 37 + (a >> 8) * 11 + c * 101);
    end
    repeat (4) @(negedge reconfig_clk);
    rst_n = 1'b1;
    @(negedge reconfig_clk);
    check_phy_outputs();

    for (int n = 0; n < NUM_XFERS; n++) begin
      if (n % 50 == 49) randomize_phy_inputs();
      ch    = $urandom_range(3, 0);
      wr    = 1'($urandom);
      wdata = $urandom;
      if ($urandom_range(1, 0) == 1) begin
        // Soft register window, mostly the mapped indices
        idx  = ($urandom_range(3, 0) == 0) ? 4'($urandom_range(15, 4)) :
                                             4'($urandom_range(3, 0));
        addr = {1'b1, 5'($urandom), idx};
        bus_access(wr, ch, addr, wdata, rdata, cycles);
        check_value("soft access cycles", cycles, 32'd4);
        if (wr) model_csr_write(ch, idx, wdata[7:0]);
        else check_value("csr readdata", rdata, {24'd0, csr_expect(ch, idx)});
      end else begin
        // Half the accesses stay in a small block so writes get read back
        addr = ($urandom_range(1, 0) == 1) ? {6'd0, 4'($urandom)} :
                                             {1'b0, 9'($urandom)};
        bus_access(wr, ch, addr, wdata, rdata, cycles);
        if (cycles < 3 || cycles > 6) begin
          $display("Transceiver access took %0d cycles, outside 3 to 6", cycles);
          abort_run();
        end
        if (wr) exp_regs[ch][addr] = wdata[7:0];
        else check_value("xcvr readdata", rdata, {24'd0, exp_regs[ch][addr]});
      end
      check_phy_outputs();
      @(negedge reconfig_clk);
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+verilog
verilog/rcfg_bus_pkg.sv
verilog/xcvr_ctrl_pkg.sv
verilog/rcfg_req_stage.sv
verilog/rcfg_soft_csr.sv
verilog/rcfg_chan_port.sv
verilog/rcfg_top.sv
tb/xcvr_avmm_responder.sv
tb/tb_rcfg_top.sv

// File: Makefile
# Verilator flow for the reconfiguration front end
VERILATOR := verilator
TOP       := tb_rcfg_top
RTL_TOP   := rcfg_top
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing -j 0
LINTFLAGS := --lint-only --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only when the run prints the pass line
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
